// ==== source/gfx_pkg.sv ====
`default_nettype none

package gfx_pkg;

    // Signed fixed point, 13 fractional bits
    localparam int DATA_W = 24;
    localparam int FRAC_W = 13;
    localparam logic signed [DATA_W-1:0] FX_ONE = 1 << FRAC_W;

    // Full product, then two levels of pair sums
    localparam int PROD_W = 2 * DATA_W;
    localparam int ACC_W  = PROD_W + 2;

    localparam int ADDR_W  = 8;
    localparam int CNT_W   = 6;
    localparam int MUL_LAT = 4;

    // Matrix row-major from 0, x/y/z triples from 16
    localparam logic [ADDR_W-1:0] MAT_BASE = '0;
    localparam logic [ADDR_W-1:0] VTX_BASE = ADDR_W'(16);

    typedef enum logic [1:0] {
        SHADER_IDLE,
        SHADER_COMPUTING,
        SHADER_FINISHED
    } shader_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT,
        FETCH_EMIT
    } fetch_state_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_READING,
        LOAD_PRESENT
    } load_state_t;

endpackage

`default_nettype wire

// ==== source/scene_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_ram (
    input  logic                       clk,

    // Host side
    input  logic                       i_wr_en,
    input  logic [gfx_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [gfx_pkg::DATA_W-1:0] i_wr_data,

    // Arbitrated read side
    input  logic                       i_rd_en,
    input  logic [gfx_pkg::ADDR_W-1:0] i_rd_addr,
    output logic [gfx_pkg::DATA_W-1:0] o_rd_data
);

    logic [gfx_pkg::DATA_W-1:0] mem [2**gfx_pkg::ADDR_W];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Data valid one cycle after the read enable
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       i_load_req,
    input  logic [gfx_pkg::ADDR_W-1:0] i_load_addr,
    input  logic                       i_fetch_req,
    input  logic [gfx_pkg::ADDR_W-1:0] i_fetch_addr,

    output logic                       o_load_gnt,
    output logic                       o_fetch_gnt,
    output logic                       o_rd_en,
    output logic [gfx_pkg::ADDR_W-1:0] o_rd_addr,

    output logic                       o_load_rvalid,
    output logic                       o_fetch_rvalid
);

    logic rd_pending;
    logic owner_load;

    // Loader wins whenever it asks
    assign o_load_gnt  = i_load_req;
    assign o_fetch_gnt = i_fetch_req && !i_load_req;
    assign o_rd_en     = i_load_req || i_fetch_req;
    assign o_rd_addr   = i_load_req ? i_load_addr : i_fetch_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_pending <= 1'b0;
            owner_load <= 1'b0;
        end else begin
            rd_pending <= o_rd_en;
            owner_load <= o_load_gnt;
        end
    end

    assign o_load_rvalid  = rd_pending && owner_load;
    assign o_fetch_rvalid = rd_pending && !owner_load;

    // A fetch that loses arbitration asks again for the same word
    a_fetch_addr_held: assert property (@(posedge clk) disable iff (!rstn)
        (i_fetch_req && !o_fetch_gnt) |=> $stable(i_fetch_addr));

endmodule

`default_nettype wire

// ==== source/matrix_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_loader (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_start,

    output logic                              o_req,
    output logic [gfx_pkg::ADDR_W-1:0]        o_addr,
    input  logic                              i_gnt,
    input  logic                              i_rvalid,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_rd_data,

    output logic signed [gfx_pkg::DATA_W-1:0] o_mvp [16],
    output logic                              o_mvp_dv
);

    gfx_pkg::load_state_t state;
    logic [3:0]           ret_cnt;

    // Matrix ends where the vertex region begins
    assign o_req    = (state == gfx_pkg::LOAD_READING) && (o_addr != gfx_pkg::VTX_BASE);
    assign o_mvp_dv = (state == gfx_pkg::LOAD_PRESENT);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= gfx_pkg::LOAD_IDLE;
            o_addr  <= gfx_pkg::MAT_BASE;
            ret_cnt <= '0;
        end else begin
            case (state)
                gfx_pkg::LOAD_IDLE: begin
                    if (i_start) begin
                        state   <= gfx_pkg::LOAD_READING;
                        o_addr  <= gfx_pkg::MAT_BASE;
                        ret_cnt <= '0;
                    end
                end
                gfx_pkg::LOAD_READING: begin
                    if (i_gnt) begin
                        o_addr <= o_addr + 1'b1;
                    end
                    if (i_rvalid) begin
                        ret_cnt <= ret_cnt + 1'b1;
                        if (ret_cnt == 4'd15) begin
                            state <= gfx_pkg::LOAD_PRESENT;
                        end
                    end
                end
                default: begin
                    state <= gfx_pkg::LOAD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rvalid) begin
            o_mvp[ret_cnt] <= i_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/vertex_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_fetch (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_start,
    input  logic [gfx_pkg::CNT_W-1:0]         i_vertex_count,
    input  logic                              i_ready,

    output logic                              o_req,
    output logic [gfx_pkg::ADDR_W-1:0]        o_addr,
    input  logic                              i_gnt,
    input  logic                              i_rvalid,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_rd_data,

    output logic signed [gfx_pkg::DATA_W-1:0] o_x,
    output logic signed [gfx_pkg::DATA_W-1:0] o_y,
    output logic signed [gfx_pkg::DATA_W-1:0] o_z,
    output logic                              o_vertex_dv,
    output logic                              o_vertex_last
);

    gfx_pkg::fetch_state_t            state;
    logic [gfx_pkg::CNT_W-1:0]        left;
    logic [1:0]                       word_idx;
    logic signed [gfx_pkg::DATA_W-1:0] words [3];

    // One word outstanding at a time
    assign o_req         = (state == gfx_pkg::FETCH_REQUEST) && i_ready;
    assign o_vertex_dv   = (state == gfx_pkg::FETCH_EMIT) && i_ready;
    assign o_vertex_last = (state == gfx_pkg::FETCH_EMIT) && (left == 1);
    assign o_x = words[0];
    assign o_y = words[1];
    assign o_z = words[2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= gfx_pkg::FETCH_IDLE;
            left     <= '0;
            word_idx <= '0;
            o_addr   <= gfx_pkg::VTX_BASE;
        end else begin
            case (state)
                gfx_pkg::FETCH_IDLE: begin
                    if (i_start && i_vertex_count != '0) begin
                        state    <= gfx_pkg::FETCH_REQUEST;
                        left     <= i_vertex_count;
                        word_idx <= '0;
                        o_addr   <= gfx_pkg::VTX_BASE;
                    end
                end
                gfx_pkg::FETCH_REQUEST: begin
                    if (i_gnt) begin
                        o_addr <= o_addr + 1'b1;
                        state  <= gfx_pkg::FETCH_WAIT;
                    end
                end
                gfx_pkg::FETCH_WAIT: begin
                    if (i_rvalid) begin
                        if (word_idx == 2'd2) begin
                            word_idx <= '0;
                            state    <= gfx_pkg::FETCH_EMIT;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            state    <= gfx_pkg::FETCH_REQUEST;
                        end
                    end
                end
                default: begin
                    // Hold the vertex until the shader takes it
                    if (i_ready) begin
                        left <= left - 1'b1;
                        if (left == 1) begin
                            state <= gfx_pkg::FETCH_IDLE;
                        end else begin
                            state <= gfx_pkg::FETCH_REQUEST;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rvalid) begin
            words[word_idx] <= i_rd_data;
        end
    end

    // Arbiter returns our word the cycle after the grant
    a_gnt_rvalid: assert property (@(posedge clk) disable iff (!rstn)
        i_gnt |=> i_rvalid);

endmodule

`default_nettype wire

// ==== source/mat_vec_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module mat_vec_mul (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_enable,

    input  logic signed [gfx_pkg::DATA_W-1:0] i_mat [16],
    input  logic signed [gfx_pkg::DATA_W-1:0] i_x,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_y,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_z,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_w,
    input  logic                              i_dv,

    output logic signed [gfx_pkg::DATA_W-1:0] o_x,
    output logic signed [gfx_pkg::DATA_W-1:0] o_y,
    output logic signed [gfx_pkg::DATA_W-1:0] o_z,
    output logic signed [gfx_pkg::DATA_W-1:0] o_w,
    output logic                              o_dv
);

    logic signed [gfx_pkg::DATA_W-1:0] vec     [4];
    logic signed [gfx_pkg::PROD_W-1:0] prod    [16];
    logic signed [gfx_pkg::PROD_W:0]   pair    [8];
    logic signed [gfx_pkg::ACC_W-1:0]  acc     [4];
    logic signed [gfx_pkg::ACC_W-1:0]  shifted [4];
    logic signed [gfx_pkg::DATA_W-1:0] res     [4];
    logic [gfx_pkg::MUL_LAT-1:0]       dv_pipe;

    assign vec[0] = i_x;
    assign vec[1] = i_y;
    assign vec[2] = i_z;
    assign vec[3] = i_w;

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            shifted[r] = acc[r] >>> gfx_pkg::FRAC_W;
        end
    end

    // Element 4*row+col pairs with vector element col
    always_ff @(posedge clk) begin
        if (i_enable) begin
            for (int i = 0; i < 16; i++) begin
                prod[i] <= i_mat[i] * vec[i % 4];
            end
            for (int i = 0; i < 8; i++) begin
                pair[i] <= prod[2*i] + prod[2*i+1];
            end
            for (int r = 0; r < 4; r++) begin
                acc[r] <= pair[2*r] + pair[2*r+1];
                res[r] <= shifted[r][gfx_pkg::DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dv_pipe <= '0;
        end else if (i_enable) begin
            dv_pipe <= {dv_pipe[gfx_pkg::MUL_LAT-2:0], i_dv};
        end
    end

    assign o_x  = res[0];
    assign o_y  = res[1];
    assign o_z  = res[2];
    assign o_w  = res[3];
    assign o_dv = dv_pipe[gfx_pkg::MUL_LAT-1];

endmodule

`default_nettype wire

// ==== source/vertex_shader.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_shader (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_enable,

    input  logic signed [gfx_pkg::DATA_W-1:0] i_mvp [16],
    input  logic                              i_mvp_dv,

    input  logic signed [gfx_pkg::DATA_W-1:0] i_x,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_y,
    input  logic signed [gfx_pkg::DATA_W-1:0] i_z,
    input  logic                              i_vertex_dv,
    input  logic                              i_vertex_last,

    output logic                              o_ready,
    output logic                              o_finished,
    output logic signed [gfx_pkg::DATA_W-1:0] o_x,
    output logic signed [gfx_pkg::DATA_W-1:0] o_y,
    output logic signed [gfx_pkg::DATA_W-1:0] o_z,
    output logic signed [gfx_pkg::DATA_W-1:0] o_w,
    output logic                              o_vertex_dv
);

    gfx_pkg::shader_state_t            state, next_state;
    logic signed [gfx_pkg::DATA_W-1:0] mvp [16];
    logic                              mvp_valid;
    logic signed [gfx_pkg::DATA_W-1:0] r_x, r_y, r_z;
    logic                              r_dv;
    // Last flag follows the vertex through register and multiplier
    logic [gfx_pkg::MUL_LAT+1:0]       last_sh;
    logic                              last_done;
    logic                              mul_dv;

    assign last_done = last_sh[gfx_pkg::MUL_LAT+1];

    mat_vec_mul mat_vec_mul_inst (
        .clk      (clk),
        .rstn     (rstn),
        .i_enable (i_enable),
        .i_mat    (mvp),
        .i_x      (r_x),
        .i_y      (r_y),
        .i_z      (r_z),
        // Homogeneous w is fixed-point one
        .i_w      (gfx_pkg::FX_ONE),
        .i_dv     (r_dv),
        .o_x      (o_x),
        .o_y      (o_y),
        .o_z      (o_z),
        .o_w      (o_w),
        .o_dv     (mul_dv)
    );

    assign o_vertex_dv = mul_dv && i_enable;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= gfx_pkg::SHADER_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        o_ready    = 1'b0;
        o_finished = 1'b0;
        case (state)
            gfx_pkg::SHADER_IDLE: begin
                if (mvp_valid) begin
                    next_state = gfx_pkg::SHADER_COMPUTING;
                end
            end
            gfx_pkg::SHADER_COMPUTING: begin
                if (!last_done) begin
                    o_ready = i_enable;
                end else if (i_enable) begin
                    o_finished = 1'b1;
                    next_state = gfx_pkg::SHADER_FINISHED;
                end
            end
            default: begin
                next_state = gfx_pkg::SHADER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mvp_valid <= 1'b0;
            r_dv      <= 1'b0;
            last_sh   <= '0;
        end else begin
            case (state)
                gfx_pkg::SHADER_IDLE: begin
                    if (i_mvp_dv) begin
                        mvp_valid <= 1'b1;
                    end
                    r_dv    <= 1'b0;
                    last_sh <= '0;
                end
                gfx_pkg::SHADER_COMPUTING: begin
                    if (i_enable) begin
                        r_dv    <= i_vertex_dv;
                        last_sh <= {last_sh[gfx_pkg::MUL_LAT:0], i_vertex_dv && i_vertex_last};
                    end
                end
                default: begin
                    mvp_valid <= 1'b0;
                    r_dv      <= 1'b0;
                end
            endcase
        end
    end

    // Matrix and registered vertex
    always_ff @(posedge clk) begin
        if (state == gfx_pkg::SHADER_IDLE && i_mvp_dv) begin
            mvp <= i_mvp;
        end
        if (state == gfx_pkg::SHADER_COMPUTING && i_enable && i_vertex_dv) begin
            r_x <= i_x;
            r_y <= i_y;
            r_z <= i_z;
        end
    end

    // Fetch must respect o_ready
    a_vertex_in_compute: assert property (@(posedge clk) disable iff (!rstn)
        i_vertex_dv |-> state == gfx_pkg::SHADER_COMPUTING);

endmodule

`default_nettype wire

// ==== source/geometry_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module geometry_top (
    input  logic                              clk,
    input  logic                              rstn,

    input  logic                              i_wr_en,
    input  logic [gfx_pkg::ADDR_W-1:0]        i_wr_addr,
    input  logic [gfx_pkg::DATA_W-1:0]        i_wr_data,

    input  logic                              i_start,
    input  logic [gfx_pkg::CNT_W-1:0]         i_vertex_count,
    input  logic                              i_enable,

    output logic signed [gfx_pkg::DATA_W-1:0] o_x,
    output logic signed [gfx_pkg::DATA_W-1:0] o_y,
    output logic signed [gfx_pkg::DATA_W-1:0] o_z,
    output logic signed [gfx_pkg::DATA_W-1:0] o_w,
    output logic                              o_vertex_dv,
    output logic                              o_finished
);

    logic                              rd_en;
    logic [gfx_pkg::ADDR_W-1:0]        rd_addr;
    logic [gfx_pkg::DATA_W-1:0]        rd_data;

    logic                              load_req, load_gnt, load_rvalid;
    logic [gfx_pkg::ADDR_W-1:0]        load_addr;
    logic                              fetch_req, fetch_gnt, fetch_rvalid;
    logic [gfx_pkg::ADDR_W-1:0]        fetch_addr;

    logic signed [gfx_pkg::DATA_W-1:0] mvp [16];
    logic                              mvp_dv;
    logic signed [gfx_pkg::DATA_W-1:0] vtx_x, vtx_y, vtx_z;
    logic                              vtx_dv, vtx_last;
    logic                              shader_ready;

    scene_ram scene_ram_inst (
        .clk       (clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    mem_arbiter mem_arbiter_inst (
        .clk            (clk),
        .rstn           (rstn),
        .i_load_req     (load_req),
        .i_load_addr    (load_addr),
        .i_fetch_req    (fetch_req),
        .i_fetch_addr   (fetch_addr),
        .o_load_gnt     (load_gnt),
        .o_fetch_gnt    (fetch_gnt),
        .o_rd_en        (rd_en),
        .o_rd_addr      (rd_addr),
        .o_load_rvalid  (load_rvalid),
        .o_fetch_rvalid (fetch_rvalid)
    );

    matrix_loader matrix_loader_inst (
        .clk       (clk),
        .rstn      (rstn),
        .i_start   (i_start),
        .o_req     (load_req),
        .o_addr    (load_addr),
        .i_gnt     (load_gnt),
        .i_rvalid  (load_rvalid),
        .i_rd_data (rd_data),
        .o_mvp     (mvp),
        .o_mvp_dv  (mvp_dv)
    );

    vertex_fetch vertex_fetch_inst (
        .clk            (clk),
        .rstn           (rstn),
        .i_start        (i_start),
        .i_vertex_count (i_vertex_count),
        .i_ready        (shader_ready),
        .o_req          (fetch_req),
        .o_addr         (fetch_addr),
        .i_gnt          (fetch_gnt),
        .i_rvalid       (fetch_rvalid),
        .i_rd_data      (rd_data),
        .o_x            (vtx_x),
        .o_y            (vtx_y),
        .o_z            (vtx_z),
        .o_vertex_dv    (vtx_dv),
        .o_vertex_last  (vtx_last)
    );

    vertex_shader vertex_shader_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_enable      (i_enable),
        .i_mvp         (mvp),
        .i_mvp_dv      (mvp_dv),
        .i_x           (vtx_x),
        .i_y           (vtx_y),
        .i_z           (vtx_z),
        .i_vertex_dv   (vtx_dv),
        .i_vertex_last (vtx_last),
        .o_ready       (shader_ready),
        .o_finished    (o_finished),
        .o_x           (o_x),
        .o_y           (o_y),
        .o_z           (o_z),
        .o_w           (o_w),
        .o_vertex_dv   (o_vertex_dv)
    );

endmodule

`default_nettype wire

// ==== bench/tb_geometry.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_geometry;

    // Vertex counts of the five runs
    localparam int TOTAL_VERTICES  = 8 + 20 + 16 + 10 + 1;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_VERTICES + 1000;

    typedef logic signed [3:0][gfx_pkg::DATA_W-1:0] vec4_t;

    logic                              clk;
    logic                              rstn;
    logic                              i_wr_en;
    logic [gfx_pkg::ADDR_W-1:0]        i_wr_addr;
    logic [gfx_pkg::DATA_W-1:0]        i_wr_data;
    logic                              i_start;
    logic [gfx_pkg::CNT_W-1:0]         i_vertex_count;
    logic                              i_enable;
    logic signed [gfx_pkg::DATA_W-1:0] o_x, o_y, o_z, o_w;
    logic                              o_vertex_dv;
    logic                              o_finished;

    logic signed [gfx_pkg::DATA_W-1:0] mat [16];
    logic signed [gfx_pkg::DATA_W-1:0] vtx [64][3];
    vec4_t                             exp_q [$];
    int                                total_seen;
    int                                finished_count;
    int                                run_target;
    int                                runs_started;

    geometry_top i_geometry_top (
        .clk            (clk),
        .rstn           (rstn),
        .i_wr_en        (i_wr_en),
        .i_wr_addr      (i_wr_addr),
        .i_wr_data      (i_wr_data),
        .i_start        (i_start),
        .i_vertex_count (i_vertex_count),
        .i_enable       (i_enable),
        .o_x            (o_x),
        .o_y            (o_y),
        .o_z            (o_z),
        .o_w            (o_w),
        .o_vertex_dv    (o_vertex_dv),
        .o_finished     (o_finished)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Row-major matrix times (x, y, z, 1.0), full precision before the shift
    function automatic vec4_t transform_ref(input logic signed [gfx_pkg::DATA_W-1:0] m [16],
                                            input logic signed [gfx_pkg::DATA_W-1:0] x,
                                            input logic signed [gfx_pkg::DATA_W-1:0] y,
                                            input logic signed [gfx_pkg::DATA_W-1:0] z);
        longint v [4];
        longint sum;
        longint q;
        vec4_t  r;
        v[0] = x;
        v[1] = y;
        v[2] = z;
        v[3] = gfx_pkg::FX_ONE;
        for (int row = 0; row < 4; row++) begin
            sum = 0;
            for (int col = 0; col < 4; col++) begin
                sum += longint'(m[4*row+col]) * v[col];
            end
            q = sum >>> gfx_pkg::FRAC_W;
            r[row] = q[gfx_pkg::DATA_W-1:0];
        end
        return r;
    endfunction

    function automatic logic signed [gfx_pkg::DATA_W-1:0] rand_fx(input int range);
        int r;
        r = int'($urandom % (2 * range + 1)) - range;
        return r[gfx_pkg::DATA_W-1:0];
    endfunction

    task automatic check_coord(input string name, input int idx,
                               input logic signed [gfx_pkg::DATA_W-1:0] got,
                               input logic signed [gfx_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %0d ns: output vertex %0d %s is %0d, expected %0d",
                                        $time, idx, name, got, exp));
        end
    endtask

    task automatic check_finished(input logic got, input logic allowed);
        if (got && !allowed) begin
            stop_with_failure($sformatf(
                "o_finished pulsed at %0d ns before the last output vertex or more than once",
                $time));
        end
    endtask

    // Compare process
    always @(posedge clk) begin
        vec4_t e;
        if (!rstn) begin
            total_seen     = 0;
            finished_count = 0;
        end else begin
            if (o_vertex_dv) begin
                if (!i_enable) begin
                    stop_with_failure("Output vertex strobe seen while i_enable is low");
                end else if (exp_q.size() == 0) begin
                    stop_with_failure("Output vertex strobe seen with no vertex expected");
                end else begin
                    e = exp_q.pop_front();
                    check_coord("x", total_seen, o_x, e[0]);
                    check_coord("y", total_seen, o_y, e[1]);
                    check_coord("z", total_seen, o_z, e[2]);
                    check_coord("w", total_seen, o_w, e[3]);
                    total_seen++;
                end
            end
            check_finished(o_finished, (exp_q.size() == 0) && (total_seen == run_target)
                                       && (finished_count < runs_started));
            if (o_finished) begin
                finished_count++;
            end
        end
    end

    task automatic write_word(input logic [gfx_pkg::ADDR_W-1:0] addr,
                              input logic [gfx_pkg::DATA_W-1:0] data);
        @(negedge clk);
        i_wr_en   = 1'b1;
        i_wr_addr = addr;
        i_wr_data = data;
    endtask

    task automatic set_identity();
        for (int i = 0; i < 16; i++) begin
            mat[i] = (i % 5 == 0) ? gfx_pkg::FX_ONE : '0;
        end
    endtask

    task automatic set_random_matrix();
        for (int i = 0; i < 16; i++) begin
            mat[i] = rand_fx(4 * gfx_pkg::FX_ONE);
        end
    endtask

    task automatic set_random_vertices(input int count, input int range);
        for (int v = 0; v < count; v++) begin
            for (int k = 0; k < 3; k++) begin
                vtx[v][k] = rand_fx(range);
            end
        end
    endtask

    // Write the scene, start one run and wait for its finished pulse
    task automatic run_vertices(input int count, input bit toggle_enable);
        int limit;
        int cycles;
        limit  = 200 * count + 200;
        cycles = 0;
        for (int i = 0; i < 16; i++) begin
            write_word(gfx_pkg::ADDR_W'(int'(gfx_pkg::MAT_BASE) + i), mat[i]);
        end
        for (int v = 0; v < count; v++) begin
            for (int k = 0; k < 3; k++) begin
                write_word(gfx_pkg::ADDR_W'(int'(gfx_pkg::VTX_BASE) + 3 * v + k), vtx[v][k]);
            end
        end
        @(negedge clk);
        i_wr_en = 1'b0;
        for (int v = 0; v < count; v++) begin
            exp_q.push_back(transform_ref(mat, vtx[v][0], vtx[v][1], vtx[v][2]));
        end
        run_target     = run_target + count;
        runs_started   = runs_started + 1;
        i_start        = 1'b1;
        i_vertex_count = gfx_pkg::CNT_W'(count);
        @(negedge clk);
        i_start = 1'b0;
        while (finished_count < runs_started) begin
            @(negedge clk);
            // Stall roughly one cycle in three
            i_enable = toggle_enable ? (($urandom % 3) != 0) : 1'b1;
            cycles++;
            if (cycles > limit) begin
                stop_with_failure($sformatf("o_finished missing: run %0d did not end in %0d cycles",
                                            runs_started, limit));
            end
        end
        i_enable = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("Timeout: the test did not complete within %0d cycles",
                                    WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(95261));
        rstn           = 1'b0;
        i_wr_en        = 1'b0;
        i_wr_addr      = '0;
        i_wr_data      = '0;
        i_start        = 1'b0;
        i_vertex_count = '0;
        i_enable       = 1'b1;
        run_target     = 0;
        runs_started   = 0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        // Identity passes vertices through
        set_identity();
        set_random_vertices(8, 64 * gfx_pkg::FX_ONE);
        run_vertices(8, 1'b0);

        set_random_matrix();
        set_random_vertices(20, 16 * gfx_pkg::FX_ONE);
        run_vertices(20, 1'b0);

        // Back-pressure through i_enable
        set_random_matrix();
        set_random_vertices(16, 16 * gfx_pkg::FX_ONE);
        run_vertices(16, 1'b1);

        set_random_matrix();
        set_random_vertices(10, 16 * gfx_pkg::FX_ONE);
        run_vertices(10, 1'b0);

        set_random_matrix();
        set_random_vertices(1, 16 * gfx_pkg::FX_ONE);
        run_vertices(1, 1'b0);

        if (exp_q.size() == 0 && total_seen == TOTAL_VERTICES) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure($sformatf("Only %0d of %0d output vertices were seen",
                                        total_seen, TOTAL_VERTICES));
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/gfx_pkg.sv
source/scene_ram.sv
source/mem_arbiter.sv
source/matrix_loader.sv
source/vertex_fetch.sv
source/mat_vec_mul.sv
source/vertex_shader.sv
source/geometry_top.sv
bench/tb_geometry.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_geometry
FILELIST := project.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
PASS_MSG := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -F -x -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
